//--- hw/noc_pkg.sv
package noc_pkg;

    localparam int NUM_PORTS = 5;
    localparam int PORT_W = $clog2(NUM_PORTS);

    typedef enum logic [PORT_W-1:0] {
        PORT_LOCAL = 3'd0,
        PORT_NORTH = 3'd1,
        PORT_EAST  = 3'd2,
        PORT_SOUTH = 3'd3,
        PORT_WEST  = 3'd4
    } port_e;

    localparam int MESH_X = 4;
    localparam int MESH_Y = 4;
    // One coordinate width covers both axes of the mesh.
    localparam int COORD_W = $clog2((MESH_X > MESH_Y) ? MESH_X : MESH_Y);

    localparam int FLIT_W = 16;
    localparam int LEN_W = 3; // Body flits after the head, so 1 to 8 flits per packet.

    // Head flit layout, with dest_x in the low bits.
    typedef struct packed {
        logic [FLIT_W-LEN_W-2*COORD_W-1:0] rsvd;
        logic [LEN_W-1:0]                  len;
        logic [COORD_W-1:0]                dest_y;
        logic [COORD_W-1:0]                dest_x;
    } head_t;

    typedef struct packed {
        logic [FLIT_W-1:0] data;
    } flit_t;

    // Request from one input toward the output arbiters.
    typedef struct packed {
        logic [NUM_PORTS-1:0] sel;  // One-hot output request.
        logic                 last; // Flit at the FIFO head ends its packet.
    } route_t;

endpackage

//--- hw/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  noc_pkg::flit_t wr_flit,
    input  logic           wr_valid,
    output logic           wr_ready,
    output noc_pkg::flit_t rd_flit,
    output logic           rd_valid,
    input  logic           rd_pop
);
    import noc_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    flit_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign rd_valid = (count != '0);
    assign rd_flit  = mem[rd_ptr];
    assign do_rd    = rd_pop && rd_valid;
    assign wr_ready = !full || do_rd; // A pop frees a slot in the same cycle.
    assign do_wr    = wr_valid && wr_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/route_compute.sv
`timescale 1ns/1ps

module route_compute #(
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  noc_pkg::flit_t                head_flit,
    input  logic                          head_valid,
    input  logic [noc_pkg::NUM_PORTS-1:0] served,
    output noc_pkg::route_t               route,
    output logic                          pop
);
    import noc_pkg::*;

    head_t            head;
    port_e            head_dir;
    port_e            cur_dir;
    port_e            dir_q;
    logic             busy;
    logic [LEN_W-1:0] left_q;

    // Only meaningful while idle, when the FIFO head is a head flit.
    assign head = head_t'(head_flit);

    // XY routing, X dimension first.
    always_comb begin
        if (head.dest_x > COORD_W'(ROUTER_X)) begin
            head_dir = PORT_EAST;
        end else if (head.dest_x < COORD_W'(ROUTER_X)) begin
            head_dir = PORT_WEST;
        end else if (head.dest_y > COORD_W'(ROUTER_Y)) begin
            head_dir = PORT_NORTH;
        end else if (head.dest_y < COORD_W'(ROUTER_Y)) begin
            head_dir = PORT_SOUTH;
        end else begin
            head_dir = PORT_LOCAL;
        end
    end

    assign cur_dir = busy ? dir_q : head_dir;

    // Request the output only while a flit is waiting.
    assign route.sel  = head_valid ? (NUM_PORTS'(1) << cur_dir) : '0;
    assign route.last = busy ? (left_q == LEN_W'(1)) : (head.len == '0);

    // At most one arbiter can serve this input in a cycle.
    assign pop = |served;

    // left_q counts the body flits still in the FIFO path, current one included.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            dir_q  <= PORT_LOCAL;
            left_q <= '0;
        end else if (pop) begin
            if (!busy) begin
                busy   <= (head.len != '0); // Single-flit packets never leave idle.
                dir_q  <= head_dir;
                left_q <= head.len;
            end else begin
                busy   <= (left_q != LEN_W'(1));
                left_q <= left_q - 1'b1;
            end
        end
    end

endmodule

//--- hw/output_arbiter.sv
`timescale 1ns/1ps

module output_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [noc_pkg::NUM_PORTS-1:0] req,
    input  logic [noc_pkg::NUM_PORTS-1:0] last,
    input  noc_pkg::flit_t                in_flit [noc_pkg::NUM_PORTS],
    output noc_pkg::flit_t                out_flit,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [noc_pkg::NUM_PORTS-1:0] served
);
    import noc_pkg::*;

    logic [PORT_W-1:0]      grant_q;
    logic [PORT_W-1:0]      next_grant;
    logic [PORT_W-1:0]      step;
    logic [PORT_W:0]        grant_sum;
    logic [2*NUM_PORTS-1:0] rotated;
    logic                   locked;
    logic                   accept;

    // Rotate so that bit 0 is the previous winner.
    assign rotated = {req, req} >> grant_q;

    // Nearest requester after the previous winner.
    // The previous winner is picked again only when nobody else asks.
    always_comb begin
        step = '0;
        for (int i = NUM_PORTS - 1; i > 0; i--) begin
            if (rotated[i]) begin
                step = PORT_W'(i);
            end
        end
    end

    assign grant_sum  = {1'b0, grant_q} + {1'b0, step};
    assign next_grant = (grant_sum >= (PORT_W + 1)'(NUM_PORTS)) ?
                        PORT_W'(grant_sum - (PORT_W + 1)'(NUM_PORTS)) :
                        PORT_W'(grant_sum);

    // Flit multiplexer, steered by the locked grant.
    assign out_flit  = in_flit[grant_q];
    assign out_valid = locked && req[grant_q];
    assign accept    = out_valid && out_ready;
    assign served    = accept ? (NUM_PORTS'(1) << grant_q) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= '0;
            locked  <= 1'b0;
        end else if (!locked) begin
            if (|req) begin
                grant_q <= next_grant;
                locked  <= 1'b1;
            end
        end else if (accept && last[grant_q]) begin
            locked <= 1'b0; // Packet is done, arbitrate again next cycle.
        end
    end

endmodule

//--- hw/noc_router.sv
`timescale 1ns/1ps

module noc_router #(
    parameter int FIFO_DEPTH = 4,
    parameter int ROUTER_X   = 1,
    parameter int ROUTER_Y   = 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  noc_pkg::flit_t                in_flit [noc_pkg::NUM_PORTS],
    input  logic [noc_pkg::NUM_PORTS-1:0] in_valid,
    output logic [noc_pkg::NUM_PORTS-1:0] in_ready,
    output noc_pkg::flit_t                out_flit [noc_pkg::NUM_PORTS],
    output logic [noc_pkg::NUM_PORTS-1:0] out_valid,
    input  logic [noc_pkg::NUM_PORTS-1:0] out_ready
);
    import noc_pkg::*;

    flit_t                head_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] head_valid;
    logic [NUM_PORTS-1:0] pop;
    route_t               route [NUM_PORTS];
    logic [NUM_PORTS-1:0] last_vec;

    // Arbiter side, indexed by output with one bit per input.
    logic [NUM_PORTS-1:0] arb_req [NUM_PORTS];
    logic [NUM_PORTS-1:0] arb_served [NUM_PORTS];

    // Route unit side, indexed by input with one bit per output.
    logic [NUM_PORTS-1:0] unit_served [NUM_PORTS];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_input
        flit_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) fifo_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_flit  (in_flit[i]),
            .wr_valid (in_valid[i]),
            .wr_ready (in_ready[i]),
            .rd_flit  (head_flit[i]),
            .rd_valid (head_valid[i]),
            .rd_pop   (pop[i])
        );

        route_compute #(
            .ROUTER_X(ROUTER_X),
            .ROUTER_Y(ROUTER_Y)
        ) route_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .head_flit  (head_flit[i]),
            .head_valid (head_valid[i]),
            .served     (unit_served[i]),
            .route      (route[i]),
            .pop        (pop[i])
        );

        assign last_vec[i] = route[i].last;

        for (genvar j = 0; j < NUM_PORTS; j++) begin : g_xpose
            assign arb_req[j][i]     = route[i].sel[j];
            assign unit_served[i][j] = arb_served[j][i];
        end
    end

    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_output
        output_arbiter arb_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .req       (arb_req[j]),
            .last      (last_vec),
            .in_flit   (head_flit),
            .out_flit  (out_flit[j]),
            .out_valid (out_valid[j]),
            .out_ready (out_ready[j]),
            .served    (arb_served[j])
        );
    end

endmodule

//--- include/noc_router_tests.svh
`ifndef NOC_ROUTER_TESTS_SVH
`define NOC_ROUTER_TESTS_SVH

// One test packet. The router under test sits at (1,1).
typedef struct packed {
    noc_pkg::port_e              src;    // Input port that sends the packet.
    logic [noc_pkg::COORD_W-1:0] dest_x;
    logic [noc_pkg::COORD_W-1:0] dest_y;
    logic [noc_pkg::LEN_W-1:0]   len;    // Body flits after the head.
    logic [7:0]                  seed;   // Start of the payload pattern.
    logic                        bp;     // Random out_ready while this row runs.
} test_row_t;

localparam int NUM_TESTS = 24;

// Rows 0 to 9 cover every routing direction, including local.
// Rows 10 to 17 load the east output from four inputs at once.
// Rows 18 to 23 run under random back-pressure.
localparam test_row_t TESTS [NUM_TESTS] = '{
    '{noc_pkg::PORT_LOCAL, 2'd2, 2'd1, 3'd2, 8'h10, 1'b0},
    '{noc_pkg::PORT_NORTH, 2'd1, 2'd1, 3'd0, 8'h20, 1'b0},
    '{noc_pkg::PORT_EAST,  2'd0, 2'd1, 3'd3, 8'h30, 1'b0},
    '{noc_pkg::PORT_SOUTH, 2'd1, 2'd3, 3'd1, 8'h40, 1'b0},
    '{noc_pkg::PORT_WEST,  2'd1, 2'd0, 3'd4, 8'h50, 1'b0},
    '{noc_pkg::PORT_LOCAL, 2'd3, 2'd3, 3'd1, 8'h18, 1'b0},
    '{noc_pkg::PORT_NORTH, 2'd0, 2'd3, 3'd2, 8'h28, 1'b0},
    '{noc_pkg::PORT_EAST,  2'd1, 2'd2, 3'd0, 8'h38, 1'b0},
    '{noc_pkg::PORT_SOUTH, 2'd3, 2'd0, 3'd5, 8'h48, 1'b0},
    '{noc_pkg::PORT_WEST,  2'd2, 2'd2, 3'd7, 8'h58, 1'b0},
    '{noc_pkg::PORT_LOCAL, 2'd3, 2'd1, 3'd1, 8'h60, 1'b0},
    '{noc_pkg::PORT_NORTH, 2'd3, 2'd1, 3'd2, 8'h68, 1'b0},
    '{noc_pkg::PORT_SOUTH, 2'd3, 2'd1, 3'd0, 8'h70, 1'b0},
    '{noc_pkg::PORT_WEST,  2'd3, 2'd1, 3'd3, 8'h78, 1'b0},
    '{noc_pkg::PORT_LOCAL, 2'd3, 2'd1, 3'd2, 8'h80, 1'b0},
    '{noc_pkg::PORT_NORTH, 2'd3, 2'd1, 3'd0, 8'h88, 1'b0},
    '{noc_pkg::PORT_SOUTH, 2'd3, 2'd1, 3'd1, 8'h90, 1'b0},
    '{noc_pkg::PORT_WEST,  2'd3, 2'd1, 3'd2, 8'h98, 1'b0},
    '{noc_pkg::PORT_LOCAL, 2'd3, 2'd2, 3'd7, 8'hA0, 1'b1},
    '{noc_pkg::PORT_NORTH, 2'd0, 2'd0, 3'd6, 8'hB0, 1'b1},
    '{noc_pkg::PORT_EAST,  2'd1, 2'd3, 3'd7, 8'hC0, 1'b1},
    '{noc_pkg::PORT_SOUTH, 2'd1, 2'd0, 3'd5, 8'hD0, 1'b1},
    '{noc_pkg::PORT_WEST,  2'd1, 2'd1, 3'd7, 8'hE0, 1'b1},
    '{noc_pkg::PORT_LOCAL, 2'd2, 2'd0, 3'd6, 8'hF0, 1'b1}
};

`endif

//--- verif/noc_router_tb.sv
`timescale 1ns/1ps

module noc_router_tb;
    import noc_pkg::*;

    `include "noc_router_tests.svh"

    localparam int ROUTER_X = 1;
    localparam int ROUTER_Y = 1;
    localparam int NUM_GROUPS = 3;
    localparam int GROUP_FIRST [NUM_GROUPS + 1] = '{0, 10, 18, 24};
    localparam int FAIR_GROUP = 1; // Four inputs racing for the east output.

    logic                 clk = 1'b0;
    logic                 rst_n;
    flit_t                in_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    flit_t                out_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_ready = '1;

    logic [31:0] rng = 32'd74;
    logic        bp_phase = 1'b0;
    logic        fair_group = 1'b0;
    logic        saw_full;
    int          cycles = 0;
    int          cycle_limit = 0;

    // Expected flits, indexed by input port and then output port.
    flit_t exp_q [NUM_PORTS][NUM_PORTS][$];
    int    pkts_left [NUM_PORTS][NUM_PORTS];
    logic  active [NUM_PORTS];
    int    act_src [NUM_PORTS];
    int    act_left [NUM_PORTS];
    logic  have_prev [NUM_PORTS];
    int    prev_src [NUM_PORTS];

    noc_router #(
        .FIFO_DEPTH(4),
        .ROUTER_X  (ROUTER_X),
        .ROUTER_Y  (ROUTER_Y)
    ) noc_router_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_flit  (out_flit),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        #1;
        if (bp_phase) begin
            rng = xorshift32(rng);
            out_ready = rng[NUM_PORTS-1:0];
        end else begin
            out_ready = '1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            abort_run("Timeout: the router did not deliver all packets in time.");
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int table_flits();
        int n;
        n = 0;
        for (int r = 0; r < NUM_TESTS; r++) begin
            n += int'(TESTS[r].len) + 1;
        end
        return n;
    endfunction

    // Dimension-ordered routing, X first.
    function automatic int route_port(input int dx, input int dy);
        int p;
        if (dx > ROUTER_X) begin
            p = int'(PORT_EAST);
        end else if (dx < ROUTER_X) begin
            p = int'(PORT_WEST);
        end else if (dy > ROUTER_Y) begin
            p = int'(PORT_NORTH);
        end else if (dy < ROUTER_Y) begin
            p = int'(PORT_SOUTH);
        end else begin
            p = int'(PORT_LOCAL);
        end
        return p;
    endfunction

    // Flit k of row r. The head carries the seed in its reserved bits, so heads are unique.
    function automatic flit_t packet_flit(input int r, input int k);
        head_t h;
        flit_t f;
        if (k == 0) begin
            h.rsvd   = {1'b0, TESTS[r].seed};
            h.len    = TESTS[r].len;
            h.dest_y = TESTS[r].dest_y;
            h.dest_x = TESTS[r].dest_x;
            f        = flit_t'(h);
        end else begin
            f.data = {TESTS[r].seed, 8'(k)};
        end
        return f;
    endfunction

    function automatic int next_in_turn(input int o, input int prev);
        int cand;
        int pick;
        pick = -1;
        for (int step = 1; step <= NUM_PORTS; step++) begin
            cand = (prev + step) % NUM_PORTS;
            if (pick < 0 && pkts_left[cand][o] > 0) begin
                pick = cand;
            end
        end
        return pick;
    endfunction

    task automatic queue_packet(input int r, output int n);
        int s;
        int o;
        s = int'(TESTS[r].src);
        o = route_port(int'(TESTS[r].dest_x), int'(TESTS[r].dest_y));
        n = int'(TESTS[r].len) + 1;
        for (int k = 0; k < n; k++) begin
            exp_q[s][o].push_back(packet_flit(r, k));
        end
        pkts_left[s][o]++;
    endtask

    task automatic take_output(input int o, input flit_t f);
        int    s;
        int    want;
        head_t h;
        if (!active[o]) begin
            s = -1;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (exp_q[i][o].size() > 0 && exp_q[i][o][0] == f) begin
                    s = i;
                end
            end
            assert (s >= 0) else report_error(
                $sformatf("unexpected flit %h on port %0d", f.data, o));
            if (fair_group && have_prev[o]) begin
                want = next_in_turn(o, prev_src[o]);
                assert (s == want) else report_error($sformatf(
                    "port %0d served input %0d, expected input %0d", o, s, want));
            end
            have_prev[o] = 1'b1;
            prev_src[o]  = s;
            pkts_left[s][o]--;
            h           = head_t'(f);
            act_src[o]  = s;
            act_left[o] = int'(h.len);
            active[o]   = (h.len != '0);
        end else begin
            s = act_src[o];
            assert (exp_q[s][o].size() > 0 && exp_q[s][o][0] == f) else report_error(
                $sformatf("port %0d got flit %h inside a packet from input %0d", o, f.data, s));
            act_left[o]--;
            active[o] = (act_left[o] != 0);
        end
        void'(exp_q[s][o].pop_front());
    endtask

    // Called just after a rising edge; returns just after the edge that took the flit.
    task automatic send_flit(input int p, input flit_t f);
        in_flit[p]  = f;
        in_valid[p] = 1'b1;
        @(negedge clk);
        while (!in_ready[p]) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid[p] = 1'b0;
    endtask

    task automatic drive_port(input int p, input int g);
        for (int r = GROUP_FIRST[g]; r < GROUP_FIRST[g + 1]; r++) begin
            if (int'(TESTS[r].src) == p) begin
                for (int k = 0; k <= int'(TESTS[r].len); k++) begin
                    send_flit(p, packet_flit(r, k));
                end
            end
        end
    endtask

    // Outputs are sampled on the falling edge, where they are stable.
    task automatic watch_outputs(input int flits);
        int taken;
        taken = 0;
        while (taken < flits) begin
            @(negedge clk);
            if (bp_phase && (|(in_valid & ~in_ready))) begin
                saw_full = 1'b1;
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (out_valid[o] && out_ready[o]) begin
                    take_output(o, out_flit[o]);
                    taken++;
                end
            end
        end
    endtask

    task automatic run_group(input int g);
        int flits;
        int n;
        flits      = 0;
        fair_group = (g == FAIR_GROUP);
        bp_phase   = TESTS[GROUP_FIRST[g]].bp;
        saw_full   = 1'b0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            have_prev[o] = 1'b0;
        end
        for (int r = GROUP_FIRST[g]; r < GROUP_FIRST[g + 1]; r++) begin
            queue_packet(r, n);
            flits += n;
        end
        @(posedge clk);
        #1;
        fork
            drive_port(0, g);
            drive_port(1, g);
            drive_port(2, g);
            drive_port(3, g);
            drive_port(4, g);
            watch_outputs(flits);
        join
        @(negedge clk);
        assert (out_valid == '0) else report_error("out_valid high after every packet arrived");
        assert (in_ready == '1) else report_error("in_ready low after the group drained");
        if (bp_phase) begin
            assert (saw_full) else report_error("in_ready never fell under back-pressure");
        end
        bp_phase = 1'b0;
    endtask

    initial begin
        cycle_limit = 64 * table_flits() + 200;
        rst_n    = 1'b0;
        in_valid = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_flit[p] = '0;
            active[p]  = 1'b0;
            for (int o = 0; o < NUM_PORTS; o++) begin
                pkts_left[p][o] = 0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        assert (out_valid == '0) else report_error("out_valid high before any input");
        for (int g = 0; g < NUM_GROUPS; g++) begin
            run_group(g);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
hw/noc_pkg.sv
hw/flit_fifo.sv
hw/route_compute.sv
hw/output_arbiter.sv
hw/noc_router.sv
verif/noc_router_tb.sv

//--- Makefile
# Verilator build and run for the NoC router testbench.

VERILATOR ?= verilator
TOP       ?= noc_router_tb
FILELIST  ?= compile.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
